//--- logic/mem_defs.svh
/*
  Memory size and address map constants for the memory subsystem.
  Include wherever the address windows or storage size are needed.
*/
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// Storage size in bytes, 64 KiB
`define MEM_BYTES 65536

// Storage size in 32-bit words
`define MEM_WORDS (`MEM_BYTES / 4)

// Main memory window, MEM_BYTES long
`define MEM_BASE 32'h0100_0000

// Alias window onto the same storage
`define MEM_ALIAS_BASE 32'h4000_0000

`endif

//--- logic/rv_isa_pkg.sv
/*
  RV32 load/store encodings and access sizes.
  Used by the load/store port to decode funct3.
*/
`default_nettype none

package rv_isa_pkg;

  // Load funct3 codes
  // Values 3'b011, 3'b110 and 3'b111 are not valid loads
  typedef enum logic [2:0] {
    FUNCT3_LB  = 3'b000,
    FUNCT3_LH  = 3'b001,
    FUNCT3_LW  = 3'b010,
    FUNCT3_LBU = 3'b100,
    FUNCT3_LHU = 3'b101
  } funct3_e;

  // Store codes share the low load values
  localparam funct3_e FUNCT3_SB = FUNCT3_LB;
  localparam funct3_e FUNCT3_SH = FUNCT3_LH;
  localparam funct3_e FUNCT3_SW = FUNCT3_LW;

  // Width of one access
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } acc_size_e;

endpackage

`default_nettype wire

//--- logic/mem_bus_pkg.sv
/*
  Request and response structs of the internal word bus and of the
  client channels. The bus carries byte strobes, clients carry funct3.
*/
`default_nettype none

package mem_bus_pkg;

  // Word request towards the memory
  // Reads keep write low, strb is then ignored
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  strb;
    logic        write;
  } bus_req_t;

  // Word response, err marks an address outside the map
  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } bus_rsp_t;

  // Load/store client request
  typedef struct packed {
    logic [31:0]         addr;
    logic [31:0]         wdata;
    rv_isa_pkg::funct3_e funct3;
    logic                store;
  } lsu_req_t;

  // Client response, shared by fetch and load/store
  // Stores and failed accesses return zero data
  typedef struct packed {
    logic [31:0] data;
    logic        err;
    logic        misaligned;
  } cli_rsp_t;

endpackage

`default_nettype wire

//--- logic/byte_mem.sv
/*
  Word-wide storage with byte strobes behind the internal bus.
  Decodes the two windows and the low range, treats address zero as null.
  Always ready and answers one cycle after each accepted request.
*/
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module byte_mem (
  input  wire logic                  clk,
  input  wire logic                  reset_i,
  input  wire logic                  req_valid_i,
  input  wire mem_bus_pkg::bus_req_t req_i,
  output logic                       req_ready_o,
  output logic                       rsp_valid_o,
  output mem_bus_pkg::bus_rsp_t      rsp_o
);

  localparam int unsigned IDX_W    = $clog2(`MEM_WORDS);
  localparam logic [31:0] MEM_SIZE = 32'(`MEM_BYTES);

  logic [31:0]      mem [`MEM_WORDS];
  logic [31:0]      offset;
  logic             in_map;
  logic             is_null;
  logic [IDX_W-1:0] idx;
  logic             wr_en;
  logic             rsp_valid_q;
  logic [31:0]      rdata_q;
  logic             err_q;

  // Storage comes up cleared
  initial begin
    for (int w = 0; w < `MEM_WORDS; w++) begin
      mem[w] = '0;
    end
  end

  // Window decode with the alias window tested first
  always_comb begin
    in_map = 1'b1;
    offset = req_i.addr;
    if (req_i.addr >= `MEM_ALIAS_BASE && req_i.addr < `MEM_ALIAS_BASE + MEM_SIZE) begin
      offset = req_i.addr - `MEM_ALIAS_BASE;
    end else if (req_i.addr >= `MEM_BASE && req_i.addr < `MEM_BASE + MEM_SIZE) begin
      offset = req_i.addr - `MEM_BASE;
    end else if (req_i.addr < MEM_SIZE) begin
      // Low addresses index the storage directly
      offset = req_i.addr;
    end else begin
      in_map = 1'b0;
      offset = '0;
    end
  end

  assign is_null = (req_i.addr == 32'h0);
  // Byte offset within the word is handled by the strobes
  assign idx     = offset[IDX_W+1:2];

  // Never stalls
  assign req_ready_o = 1'b1;

  // Null and unmapped addresses never write
  assign wr_en = req_valid_i & req_ready_o & req_i.write & in_map & ~is_null;

  always @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < 4; b++) begin
        if (req_i.strb[b]) begin
          mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_valid_i & req_ready_o;
    end
  end

  // Registered read data and error flag
  always_ff @(posedge clk) begin
    if (req_valid_i && req_ready_o) begin
      err_q <= ~in_map;
      if (req_i.write || !in_map || is_null) begin
        rdata_q <= '0;
      end else begin
        rdata_q <= mem[idx];
      end
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o.rdata = rdata_q;
  assign rsp_o.err   = err_q;

endmodule

`default_nettype wire

//--- logic/mem_arbiter.sv
/*
  Two-master round-robin arbiter in front of the memory.
  Request handshake passes through combinationally, the registered winner
  steers the response valid one cycle later. Master 0 wins first after reset.
*/
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
  input  wire logic                  clk,
  input  wire logic                  reset_i,
  // Master 0, the fetch port
  input  wire logic                  m0_valid_i,
  input  wire mem_bus_pkg::bus_req_t m0_req_i,
  output logic                       m0_ready_o,
  output logic                       m0_rsp_valid_o,
  // Master 1, the load/store port
  input  wire logic                  m1_valid_i,
  input  wire mem_bus_pkg::bus_req_t m1_req_i,
  output logic                       m1_ready_o,
  output logic                       m1_rsp_valid_o,
  // Slave side
  output logic                       s_valid_o,
  output mem_bus_pkg::bus_req_t      s_req_o,
  input  wire logic                  s_ready_i,
  input  wire logic                  s_rsp_valid_i
);

  logic grant_m1;
  logic accept;
  // Last winner, 1 means master 1
  // Also names the owner of the response due next cycle
  logic winner_q;

  // Master 1 wins when alone, or when both ask and master 0 won last
  assign grant_m1 = m1_valid_i & (~m0_valid_i | ~winner_q);

  assign s_valid_o = m0_valid_i | m1_valid_i;
  assign s_req_o   = grant_m1 ? m1_req_i : m0_req_i;

  assign m0_ready_o = s_ready_i & ~grant_m1;
  assign m1_ready_o = s_ready_i & grant_m1;

  assign accept = s_valid_o & s_ready_i;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      // Pretend master 1 won so fetch has priority first
      winner_q <= 1'b1;
    end else if (accept) begin
      winner_q <= grant_m1;
    end
  end

  // Memory answers exactly one cycle after acceptance
  // so the winner register still holds the owner
  assign m0_rsp_valid_o = s_rsp_valid_i & ~winner_q;
  assign m1_rsp_valid_o = s_rsp_valid_i & winner_q;

endmodule

`default_nettype wire

//--- logic/lsu_port.sv
/*
  Load/store client port. Decodes funct3, checks alignment, places store
  data in byte lanes and extends load data from the returned word.
  Bad requests answer locally, one response is buffered until taken.
*/
`timescale 1ns/1ps
`default_nettype none

module lsu_port (
  input  wire logic                  clk,
  input  wire logic                  reset_i,
  // Client side
  input  wire logic                  req_valid_i,
  input  wire mem_bus_pkg::lsu_req_t req_i,
  output logic                       req_ready_o,
  output logic                       rsp_valid_o,
  output mem_bus_pkg::cli_rsp_t      rsp_o,
  input  wire logic                  rsp_ready_i,
  // Bus side
  output logic                       bus_valid_o,
  output mem_bus_pkg::bus_req_t      bus_req_o,
  input  wire logic                  bus_ready_i,
  input  wire logic                  bus_rsp_valid_i,
  input  wire mem_bus_pkg::bus_rsp_t bus_rsp_i
);

  import rv_isa_pkg::*;
  import mem_bus_pkg::*;

  acc_size_e   size;
  logic        sign_ext;
  logic        legal;
  logic        misal;
  logic        bad;
  logic        idle;
  logic        bus_acc;
  logic        loc_acc;
  logic [1:0]  off;
  logic [3:0]  strb;
  // Outstanding load state
  acc_size_e   size_q;
  logic        sign_q;
  logic [1:0]  off_q;
  logic        store_q;
  logic [31:0] lane;
  logic [31:0] load_data;
  // Response buffer
  logic        rsp_full_q;
  cli_rsp_t    rsp_q;

  // funct3 decode, stores have no unsigned forms
  always_comb begin
    size     = SIZE_WORD;
    sign_ext = 1'b0;
    legal    = 1'b1;
    if (req_i.store) begin
      case (req_i.funct3)
        FUNCT3_SB: size = SIZE_BYTE;
        FUNCT3_SH: size = SIZE_HALF;
        FUNCT3_SW: size = SIZE_WORD;
        default:   legal = 1'b0;
      endcase
    end else begin
      case (req_i.funct3)
        FUNCT3_LB: begin
          size     = SIZE_BYTE;
          sign_ext = 1'b1;
        end
        FUNCT3_LH: begin
          size     = SIZE_HALF;
          sign_ext = 1'b1;
        end
        FUNCT3_LW:  size = SIZE_WORD;
        FUNCT3_LBU: size = SIZE_BYTE;
        FUNCT3_LHU: size = SIZE_HALF;
        default:    legal = 1'b0;
      endcase
    end
  end

  assign off = req_i.addr[1:0];

  // Natural alignment and lane strobes
  always_comb begin
    case (size)
      SIZE_BYTE: begin
        misal = 1'b0;
        strb  = 4'b0001 << off;
      end
      SIZE_HALF: begin
        misal = off[0];
        strb  = 4'b0011 << off;
      end
      default: begin
        misal = |off;
        strb  = 4'b1111;
      end
    endcase
  end

  assign bad = ~legal | misal;

  // A response arriving this cycle still occupies the buffer
  assign idle = ~rsp_full_q & ~bus_rsp_valid_i;

  assign bus_valid_o = req_valid_i & idle & ~bad;
  assign req_ready_o = idle & (bad | bus_ready_i);

  assign bus_acc = bus_valid_o & bus_ready_i;
  assign loc_acc = req_valid_i & req_ready_o & bad;

  // Store data shifted into its byte lanes, strobes mask the rest
  assign bus_req_o.addr  = req_i.addr;
  assign bus_req_o.wdata = req_i.wdata << {off, 3'b000};
  assign bus_req_o.strb  = strb;
  assign bus_req_o.write = req_i.store;

  always_ff @(posedge clk) begin
    if (bus_acc) begin
      size_q  <= size;
      sign_q  <= sign_ext;
      off_q   <= off;
      store_q <= req_i.store;
    end
  end

  // Lane select and extension of the returned word
  assign lane = bus_rsp_i.rdata >> {off_q, 3'b000};

  always_comb begin
    case (size_q)
      SIZE_BYTE: load_data = {{24{sign_q & lane[7]}}, lane[7:0]};
      SIZE_HALF: load_data = {{16{sign_q & lane[15]}}, lane[15:0]};
      default:   load_data = lane;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      rsp_full_q <= 1'b0;
    end else if (bus_rsp_valid_i || loc_acc) begin
      rsp_full_q <= 1'b1;
    end else if (rsp_full_q && rsp_ready_i) begin
      rsp_full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (bus_rsp_valid_i) begin
      rsp_q.data       <= store_q ? '0 : load_data;
      rsp_q.err        <= bus_rsp_i.err;
      rsp_q.misaligned <= 1'b0;
    end else if (loc_acc) begin
      // Unknown funct3 reports err, otherwise misalignment
      rsp_q.data       <= '0;
      rsp_q.err        <= ~legal;
      rsp_q.misaligned <= legal;
    end
  end

  assign rsp_valid_o = rsp_full_q;
  assign rsp_o       = rsp_q;

endmodule

`default_nettype wire

//--- logic/ifetch_port.sv
/*
  Instruction fetch client port. Issues full-word reads, flags addresses
  off a word boundary as misaligned without a bus access, and buffers
  one response until the client takes it.
*/
`timescale 1ns/1ps
`default_nettype none

module ifetch_port (
  input  wire logic                  clk,
  input  wire logic                  reset_i,
  // Client side
  input  wire logic                  req_valid_i,
  input  wire logic [31:0]           req_addr_i,
  output logic                       req_ready_o,
  output logic                       rsp_valid_o,
  output mem_bus_pkg::cli_rsp_t      rsp_o,
  input  wire logic                  rsp_ready_i,
  // Bus side
  output logic                       bus_valid_o,
  output mem_bus_pkg::bus_req_t      bus_req_o,
  input  wire logic                  bus_ready_i,
  input  wire logic                  bus_rsp_valid_i,
  input  wire mem_bus_pkg::bus_rsp_t bus_rsp_i
);

  import mem_bus_pkg::*;

  logic     misal;
  logic     idle;
  logic     loc_acc;
  logic     rsp_full_q;
  cli_rsp_t rsp_q;

  assign misal = |req_addr_i[1:0];

  // Busy while a response is buffered or arriving
  assign idle = ~rsp_full_q & ~bus_rsp_valid_i;

  assign bus_valid_o = req_valid_i & idle & ~misal;
  assign req_ready_o = idle & (misal | bus_ready_i);
  assign loc_acc     = req_valid_i & req_ready_o & misal;

  // Plain word read
  assign bus_req_o.addr  = req_addr_i;
  assign bus_req_o.wdata = '0;
  assign bus_req_o.strb  = '0;
  assign bus_req_o.write = 1'b0;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      rsp_full_q <= 1'b0;
    end else if (bus_rsp_valid_i || loc_acc) begin
      rsp_full_q <= 1'b1;
    end else if (rsp_full_q && rsp_ready_i) begin
      rsp_full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (bus_rsp_valid_i) begin
      rsp_q.data       <= bus_rsp_i.rdata;
      rsp_q.err        <= bus_rsp_i.err;
      rsp_q.misaligned <= 1'b0;
    end else if (loc_acc) begin
      rsp_q.data       <= '0;
      rsp_q.err        <= 1'b0;
      rsp_q.misaligned <= 1'b1;
    end
  end

  assign rsp_valid_o = rsp_full_q;
  assign rsp_o       = rsp_q;

endmodule

`default_nettype wire

//--- logic/mem_subsystem.sv
/*
  Memory subsystem top. Fetch and load/store ports share one memory
  through a round-robin arbiter; fetch is master 0.
*/
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem (
  input  wire logic                  clk,
  input  wire logic                  reset_i,
  // Fetch channel
  input  wire logic                  fetch_req_valid_i,
  input  wire logic [31:0]           fetch_req_i,
  output logic                       fetch_req_ready_o,
  output logic                       fetch_rsp_valid_o,
  output mem_bus_pkg::cli_rsp_t      fetch_rsp_o,
  input  wire logic                  fetch_rsp_ready_i,
  // Load/store channel
  input  wire logic                  lsu_req_valid_i,
  input  wire mem_bus_pkg::lsu_req_t lsu_req_i,
  output logic                       lsu_req_ready_o,
  output logic                       lsu_rsp_valid_o,
  output mem_bus_pkg::cli_rsp_t      lsu_rsp_o,
  input  wire logic                  lsu_rsp_ready_i
);

  import mem_bus_pkg::*;

  logic     fetch_bus_valid;
  bus_req_t fetch_bus_req;
  logic     fetch_bus_ready;
  logic     fetch_bus_rsp_valid;
  logic     lsu_bus_valid;
  bus_req_t lsu_bus_req;
  logic     lsu_bus_ready;
  logic     lsu_bus_rsp_valid;
  logic     mem_valid;
  bus_req_t mem_req;
  logic     mem_ready;
  logic     mem_rsp_valid;
  // Response payload goes to both ports, valid is routed
  bus_rsp_t mem_rsp;

  ifetch_port i_ifetch_port (
    .clk,
    .reset_i,
    .req_valid_i     (fetch_req_valid_i),
    .req_addr_i      (fetch_req_i),
    .req_ready_o     (fetch_req_ready_o),
    .rsp_valid_o     (fetch_rsp_valid_o),
    .rsp_o           (fetch_rsp_o),
    .rsp_ready_i     (fetch_rsp_ready_i),
    .bus_valid_o     (fetch_bus_valid),
    .bus_req_o       (fetch_bus_req),
    .bus_ready_i     (fetch_bus_ready),
    .bus_rsp_valid_i (fetch_bus_rsp_valid),
    .bus_rsp_i       (mem_rsp)
  );

  lsu_port i_lsu_port (
    .clk,
    .reset_i,
    .req_valid_i     (lsu_req_valid_i),
    .req_i           (lsu_req_i),
    .req_ready_o     (lsu_req_ready_o),
    .rsp_valid_o     (lsu_rsp_valid_o),
    .rsp_o           (lsu_rsp_o),
    .rsp_ready_i     (lsu_rsp_ready_i),
    .bus_valid_o     (lsu_bus_valid),
    .bus_req_o       (lsu_bus_req),
    .bus_ready_i     (lsu_bus_ready),
    .bus_rsp_valid_i (lsu_bus_rsp_valid),
    .bus_rsp_i       (mem_rsp)
  );

  mem_arbiter i_mem_arbiter (
    .clk,
    .reset_i,
    .m0_valid_i     (fetch_bus_valid),
    .m0_req_i       (fetch_bus_req),
    .m0_ready_o     (fetch_bus_ready),
    .m0_rsp_valid_o (fetch_bus_rsp_valid),
    .m1_valid_i     (lsu_bus_valid),
    .m1_req_i       (lsu_bus_req),
    .m1_ready_o     (lsu_bus_ready),
    .m1_rsp_valid_o (lsu_bus_rsp_valid),
    .s_valid_o      (mem_valid),
    .s_req_o        (mem_req),
    .s_ready_i      (mem_ready),
    .s_rsp_valid_i  (mem_rsp_valid)
  );

  byte_mem i_byte_mem (
    .clk,
    .reset_i,
    .req_valid_i (mem_valid),
    .req_i       (mem_req),
    .req_ready_o (mem_ready),
    .rsp_valid_o (mem_rsp_valid),
    .rsp_o       (mem_rsp)
  );

endmodule

`default_nettype wire

//--- verification/mem_subsystem_asserts.sv
/*
  Protocol checks on the client channels of the memory subsystem.
  Bound into every mem_subsystem instance, counts failed checks in fail_cnt.
*/
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_asserts (
  input wire logic                  clk,
  input wire logic                  reset_i,
  input wire logic                  fetch_req_valid_i,
  input wire logic [31:0]           fetch_req_i,
  input wire logic                  fetch_req_ready_i,
  input wire logic                  fetch_rsp_valid_i,
  input wire mem_bus_pkg::cli_rsp_t fetch_rsp_i,
  input wire logic                  fetch_rsp_ready_i,
  input wire logic                  lsu_req_valid_i,
  input wire mem_bus_pkg::lsu_req_t lsu_req_i,
  input wire logic                  lsu_req_ready_i,
  input wire logic                  lsu_rsp_valid_i,
  input wire mem_bus_pkg::cli_rsp_t lsu_rsp_i,
  input wire logic                  lsu_rsp_ready_i
);

  int   fail_cnt;
  // Set once a channel has accepted its first request
  logic fetch_seen_q;
  logic lsu_seen_q;

  initial begin
    fail_cnt = 0;
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      fetch_seen_q <= 1'b0;
      lsu_seen_q   <= 1'b0;
    end else begin
      fetch_seen_q <= fetch_seen_q | (fetch_req_valid_i & fetch_req_ready_i);
      lsu_seen_q   <= lsu_seen_q | (lsu_req_valid_i & lsu_req_ready_i);
    end
  end

  // Requests hold while stalled
  fetch_req_hold: assert property (@(posedge clk) disable iff (reset_i)
    fetch_req_valid_i && !fetch_req_ready_i |=> fetch_req_valid_i && $stable(fetch_req_i))
  else begin
    $error("fetch request changed while stalled");
    fail_cnt++;
  end

  lsu_req_hold: assert property (@(posedge clk) disable iff (reset_i)
    lsu_req_valid_i && !lsu_req_ready_i |=> lsu_req_valid_i && $stable(lsu_req_i))
  else begin
    $error("load/store request changed while stalled");
    fail_cnt++;
  end

  // Responses hold until taken
  fetch_rsp_hold: assert property (@(posedge clk) disable iff (reset_i)
    fetch_rsp_valid_i && !fetch_rsp_ready_i |=> fetch_rsp_valid_i && $stable(fetch_rsp_i))
  else begin
    $error("fetch response changed while stalled");
    fail_cnt++;
  end

  lsu_rsp_hold: assert property (@(posedge clk) disable iff (reset_i)
    lsu_rsp_valid_i && !lsu_rsp_ready_i |=> lsu_rsp_valid_i && $stable(lsu_rsp_i))
  else begin
    $error("load/store response changed while stalled");
    fail_cnt++;
  end

  // Back-pressure, a buffered response blocks new requests
  fetch_busy: assert property (@(posedge clk) disable iff (reset_i)
    fetch_rsp_valid_i |-> !fetch_req_ready_i)
  else begin
    $error("fetch request ready while a response waits");
    fail_cnt++;
  end

  lsu_busy: assert property (@(posedge clk) disable iff (reset_i)
    lsu_rsp_valid_i |-> !lsu_req_ready_i)
  else begin
    $error("load/store request ready while a response waits");
    fail_cnt++;
  end

  // No response out of nowhere
  fetch_no_early: assert property (@(posedge clk) disable iff (reset_i)
    !fetch_seen_q |-> !fetch_rsp_valid_i)
  else begin
    $error("fetch response before any request");
    fail_cnt++;
  end

  lsu_no_early: assert property (@(posedge clk) disable iff (reset_i)
    !lsu_seen_q |-> !lsu_rsp_valid_i)
  else begin
    $error("load/store response before any request");
    fail_cnt++;
  end

endmodule

bind mem_subsystem mem_subsystem_asserts i_asserts (
  .clk,
  .reset_i,
  .fetch_req_valid_i,
  .fetch_req_i,
  .fetch_req_ready_i (fetch_req_ready_o),
  .fetch_rsp_valid_i (fetch_rsp_valid_o),
  .fetch_rsp_i       (fetch_rsp_o),
  .fetch_rsp_ready_i,
  .lsu_req_valid_i,
  .lsu_req_i,
  .lsu_req_ready_i   (lsu_req_ready_o),
  .lsu_rsp_valid_i   (lsu_rsp_valid_o),
  .lsu_rsp_i         (lsu_rsp_o),
  .lsu_rsp_ready_i
);

`default_nettype wire

//--- verification/mem_subsystem_tb.sv
/*
  Testbench for the memory subsystem. Queues directed and LFSR driven
  requests on both client channels, mirrors stores in a byte array and
  checks every response, its latency, its order and the bus grant order.
*/
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module mem_subsystem_tb;

  import rv_isa_pkg::*;
  import mem_bus_pkg::*;

  localparam int N_TESTS  = 300;
  localparam int WD_CYCLES = (2 * N_TESTS + 100) * 20;

  logic     clk;
  logic     reset_i;
  logic     fetch_req_valid_i;
  logic [31:0] fetch_req_i;
  logic     fetch_req_ready_o;
  logic     fetch_rsp_valid_o;
  cli_rsp_t fetch_rsp_o;
  logic     fetch_rsp_ready_i;
  logic     lsu_req_valid_i;
  lsu_req_t lsu_req_i;
  logic     lsu_req_ready_o;
  logic     lsu_rsp_valid_o;
  cli_rsp_t lsu_rsp_o;
  logic     lsu_rsp_ready_i;

  logic [15:0] lfsr;
  logic        run;
  logic        f_acc;
  logic        l_acc;
  int          cycle;
  // Shadow of the storage with one byte per entry
  logic [7:0]  shadow [`MEM_BYTES];
  // Pending stimulus
  logic [31:0] fetch_todo [$];
  lsu_req_t    lsu_todo [$];
  // Expected responses in acceptance order
  cli_rsp_t    fetch_exp [$];
  cli_rsp_t    lsu_exp [$];
  int          fetch_lat [$];
  int          lsu_lat [$];
  int          fetch_at [$];
  int          lsu_at [$];
  logic        fetch_seen;
  logic        lsu_seen;
  // Ports asking for the bus this cycle
  logic        fetch_bus;
  logic        lsu_bus;
  // Last bus winner, 1 means the load/store port
  logic        last_m1;

  mem_subsystem i_dut (.*);

  always #50 clk = ~clk;

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1);
  endtask

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      v[i] = lfsr[0];
    end
    return v;
  endfunction

  // Maps an address to a storage offset and returns 0 outside all windows
  function automatic logic map_offset(input logic [31:0] addr, output logic [31:0] off);
    off = '0;
    map_offset = 1'b1;
    if (addr >= `MEM_ALIAS_BASE && addr < `MEM_ALIAS_BASE + `MEM_BYTES) begin
      off = addr - `MEM_ALIAS_BASE;
    end else if (addr >= `MEM_BASE && addr < `MEM_BASE + `MEM_BYTES) begin
      off = addr - `MEM_BASE;
    end else if (addr < `MEM_BYTES) begin
      off = addr;
    end else begin
      map_offset = 1'b0;
    end
  endfunction

  // True when the port answers without a bus access
  function automatic logic lsu_is_local(input lsu_req_t r);
    logic [2:0] f3;
    f3 = r.funct3;
    if (r.store ? (f3 > 3'd2) : (f3 == 3'd3 || f3 > 3'd5)) begin
      return 1'b1;
    end
    return (r.addr % (32'd1 << f3[1:0])) != 0;
  endfunction

  // Expected load/store result that also applies stores to the shadow
  function automatic cli_rsp_t lsu_model(input lsu_req_t r);
    cli_rsp_t    rsp;
    logic [2:0]  f3;
    logic [31:0] off;
    logic [31:0] word;
    int          nb;
    rsp = '0;
    word = '0;
    f3 = r.funct3;
    if (r.store ? (f3 > 3'd2) : (f3 == 3'd3 || f3 > 3'd5)) begin
      rsp.err = 1'b1;
      return rsp;
    end
    nb = 1 << f3[1:0];
    if ((r.addr % nb) != 0) begin
      rsp.misaligned = 1'b1;
      return rsp;
    end
    if (!map_offset(r.addr, off)) begin
      rsp.err = 1'b1;
      return rsp;
    end
    // Null location
    if (r.addr == 32'h0) begin
      return rsp;
    end
    for (int i = 0; i < nb; i++) begin
      if (r.store) begin
        shadow[off + i] = r.wdata[8*i +: 8];
      end else begin
        word[8*i +: 8] = shadow[off + i];
      end
    end
    if (!r.store && !f3[2] && nb < 4 && word[8*nb-1]) begin
      word = word | (~32'h0 << (8 * nb));
    end
    rsp.data = r.store ? '0 : word;
    return rsp;
  endfunction

  function automatic cli_rsp_t fetch_model(input logic [31:0] addr);
    cli_rsp_t    rsp;
    logic [31:0] off;
    rsp = '0;
    if (addr[1:0] != 2'b00) begin
      rsp.misaligned = 1'b1;
    end else if (!map_offset(addr, off)) begin
      rsp.err = 1'b1;
    end else if (addr != 32'h0) begin
      rsp.data = {shadow[off + 3], shadow[off + 2], shadow[off + 1], shadow[off]};
    end
    return rsp;
  endfunction

  task automatic push_lsu(input logic [31:0] addr, input funct3_e f3, input logic st,
                          input logic [31:0] data);
    lsu_req_t r;
    r.addr   = addr;
    r.funct3 = f3;
    r.store  = st;
    r.wdata  = data;
    lsu_todo.push_back(r);
  endtask

  // Window 3 is outside the map or the null location
  function automatic logic [31:0] pick_addr();
    logic [31:0] off;
    logic [1:0]  sel;
    sel = rand_bits(2);
    off = rand_bits(8);
    case (sel)
      2'd0:    pick_addr = off;
      2'd1:    pick_addr = `MEM_BASE + off;
      2'd2:    pick_addr = `MEM_ALIAS_BASE + off;
      default: pick_addr = rand_bits(1) ? 32'h0 : 32'h2000_0000 + off;
    endcase
  endfunction

  task automatic wait_drained();
    do begin
      @(posedge clk);
    end while (fetch_todo.size() != 0 || lsu_todo.size() != 0 || fetch_req_valid_i ||
               lsu_req_valid_i || fetch_exp.size() != 0 || lsu_exp.size() != 0);
    @(negedge clk);
  endtask

  // Driver and only user of the LFSR while requests flow
  always begin
    @(posedge clk);
    f_acc = fetch_req_valid_i && fetch_req_ready_o;
    l_acc = lsu_req_valid_i && lsu_req_ready_o;
    #1;
    if (run) begin
      if (f_acc || !fetch_req_valid_i) begin
        fetch_req_valid_i = 1'b0;
        if (fetch_todo.size() != 0 && rand_bits(2) != 0) begin
          fetch_req_valid_i = 1'b1;
          fetch_req_i = fetch_todo.pop_front();
        end
      end
      if (l_acc || !lsu_req_valid_i) begin
        lsu_req_valid_i = 1'b0;
        if (lsu_todo.size() != 0 && rand_bits(2) != 0) begin
          lsu_req_valid_i = 1'b1;
          lsu_req_i = lsu_todo.pop_front();
        end
      end
      // Random stalls on the response side
      fetch_rsp_ready_i = rand_bits(2) != 0;
      lsu_rsp_ready_i   = rand_bits(2) != 0;
    end
  end

  // Monitor sampling at the rising edge
  always @(posedge clk) begin
    if (!reset_i) begin
      assert (i_dut.i_asserts.fail_cnt == 0)
      else report_failure("protocol assertion failed on a client channel");
      // A port with nothing outstanding and a bus request competes for the grant
      fetch_bus = fetch_req_valid_i && fetch_exp.size() == 0 && fetch_req_i[1:0] == 2'b00;
      lsu_bus   = lsu_req_valid_i && lsu_exp.size() == 0 && !lsu_is_local(lsu_req_i);
      // Round-robin, the last winner yields
      if (fetch_bus && lsu_bus) begin
        assert ({fetch_req_ready_o, lsu_req_ready_o} == {last_m1, ~last_m1})
        else report_failure($sformatf(
          "** Error: fetch_req_ready_o,lsu_req_ready_o got %h expected %h",
          {fetch_req_ready_o, lsu_req_ready_o}, {last_m1, ~last_m1}));
      end
      if (fetch_req_valid_i && fetch_req_ready_o) begin
        fetch_exp.push_back(fetch_model(fetch_req_i));
        fetch_lat.push_back(fetch_req_i[1:0] != 2'b00 ? 1 : 2);
        fetch_at.push_back(cycle);
        if (fetch_req_i[1:0] == 2'b00) begin
          last_m1 = 1'b0;
        end
      end
      if (lsu_req_valid_i && lsu_req_ready_o) begin
        lsu_lat.push_back(lsu_is_local(lsu_req_i) ? 1 : 2);
        if (!lsu_is_local(lsu_req_i)) begin
          last_m1 = 1'b1;
        end
        lsu_exp.push_back(lsu_model(lsu_req_i));
        lsu_at.push_back(cycle);
      end
      // Fetch response latency on first sight and value at the handshake
      if (fetch_rsp_valid_o) begin
        assert (fetch_exp.size() != 0)
        else report_failure("fetch response with no request outstanding");
        if (!fetch_seen) begin
          assert (cycle - fetch_at[0] == fetch_lat[0])
          else report_failure($sformatf("** Error: fetch_rsp_valid_o latency %h expected %h",
                                        cycle - fetch_at[0], fetch_lat[0]));
          fetch_seen = 1'b1;
        end
        if (fetch_rsp_ready_i) begin
          assert (fetch_rsp_o == fetch_exp[0])
          else report_failure($sformatf("** Error: fetch_rsp_o got %h expected %h",
                                        fetch_rsp_o, fetch_exp[0]));
          void'(fetch_exp.pop_front());
          void'(fetch_lat.pop_front());
          void'(fetch_at.pop_front());
          fetch_seen = 1'b0;
        end
      end
      if (lsu_rsp_valid_o) begin
        assert (lsu_exp.size() != 0)
        else report_failure("load/store response with no request outstanding");
        if (!lsu_seen) begin
          assert (cycle - lsu_at[0] == lsu_lat[0])
          else report_failure($sformatf("** Error: lsu_rsp_valid_o latency %h expected %h",
                                        cycle - lsu_at[0], lsu_lat[0]));
          lsu_seen = 1'b1;
        end
        if (lsu_rsp_ready_i) begin
          assert (lsu_rsp_o == lsu_exp[0])
          else report_failure($sformatf("** Error: lsu_rsp_o got %h expected %h",
                                        lsu_rsp_o, lsu_exp[0]));
          void'(lsu_exp.pop_front());
          void'(lsu_lat.pop_front());
          void'(lsu_at.pop_front());
          lsu_seen = 1'b0;
        end
      end
    end
    cycle = cycle + 1;
  end

  // Watchdog
  initial begin
    #(WD_CYCLES * 100);
    report_failure("watchdog expired before the tests finished");
  end

  initial begin
    logic [31:0] bases [3];
    logic [31:0] a;
    lsu_req_t    r;
    clk = 1'b0;
    reset_i = 1'b1;
    run = 1'b0;
    lfsr = 16'd61247;
    cycle = 0;
    fetch_seen = 1'b0;
    lsu_seen = 1'b0;
    fetch_bus = 1'b0;
    lsu_bus = 1'b0;
    // Fetch has priority first after reset
    last_m1 = 1'b1;
    fetch_req_valid_i = 1'b0;
    fetch_req_i = '0;
    fetch_rsp_ready_i = 1'b0;
    lsu_req_valid_i = 1'b0;
    lsu_req_i = '0;
    lsu_rsp_ready_i = 1'b0;
    for (int i = 0; i < `MEM_BYTES; i++) begin
      shadow[i] = '0;
    end
    bases[0] = 32'h0;
    bases[1] = `MEM_BASE;
    bases[2] = `MEM_ALIAS_BASE;
    repeat (16) @(posedge clk);
    #1;
    reset_i = 1'b0;
    @(negedge clk);
    run = 1'b1;

    // Each size stored and loaded through every window
    for (int k = 0; k < 3; k++) begin
      push_lsu(bases[k] + 32'h100, FUNCT3_SW, 1'b1, rand_bits(32));
      push_lsu(bases[k] + 32'h101, FUNCT3_SB, 1'b1, 32'h80);
      push_lsu(bases[k] + 32'h102, FUNCT3_SH, 1'b1, 32'h8001);
      push_lsu(bases[k] + 32'h101, FUNCT3_LB, 1'b0, '0);
      push_lsu(bases[k] + 32'h101, FUNCT3_LBU, 1'b0, '0);
      push_lsu(bases[k] + 32'h102, FUNCT3_LH, 1'b0, '0);
      push_lsu(bases[k] + 32'h102, FUNCT3_LHU, 1'b0, '0);
      push_lsu(bases[k] + 32'h100, FUNCT3_LW, 1'b0, '0);
      push_lsu(bases[(k + 1) % 3] + 32'h100, FUNCT3_LW, 1'b0, '0);
      fetch_todo.push_back(bases[k] + 32'h100);
    end
    // Outside the map and the null location
    push_lsu(32'h2000_0000, FUNCT3_SW, 1'b1, 32'hDEAD_BEEF);
    push_lsu(32'h2000_0000, FUNCT3_LW, 1'b0, '0);
    push_lsu(32'h0, FUNCT3_SW, 1'b1, 32'hCAFE_F00D);
    push_lsu(32'h0, FUNCT3_LW, 1'b0, '0);
    push_lsu(`MEM_BASE, FUNCT3_LW, 1'b0, '0);
    fetch_todo.push_back(32'h2000_0000);
    fetch_todo.push_back(32'h0);
    // Misaligned and unknown funct3
    push_lsu(32'h101, FUNCT3_LH, 1'b0, '0);
    push_lsu(32'h102, FUNCT3_LW, 1'b0, '0);
    push_lsu(32'h103, FUNCT3_SW, 1'b1, 32'h1234_5678);
    push_lsu(32'h103, FUNCT3_SH, 1'b1, 32'h1234_5678);
    push_lsu(32'h100, FUNCT3_LW, 1'b0, '0);
    push_lsu(32'h100, funct3_e'(3'b011), 1'b0, '0);
    push_lsu(32'h100, funct3_e'(3'b100), 1'b1, 32'h55);
    fetch_todo.push_back(32'h102);
    fetch_todo.push_back(`MEM_BASE + 32'h101);
    wait_drained();

    // Random concurrent traffic
    for (int n = 0; n < N_TESTS; n++) begin
      a = pick_addr();
      if (rand_bits(3) != 0) begin
        a[1:0] = 2'b00;
      end
      fetch_todo.push_back(a);
      r.addr   = pick_addr();
      r.funct3 = funct3_e'(rand_bits(3));
      r.store  = rand_bits(1);
      r.wdata  = rand_bits(32);
      if (rand_bits(2) != 0) begin
        r.addr = r.addr & ~((32'h1 << r.funct3[1:0]) - 32'h1);
      end
      lsu_todo.push_back(r);
    end
    wait_drained();
    repeat (4) @(posedge clk);

    if (i_dut.i_asserts.fail_cnt == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      report_failure("protocol assertion failed on a client channel");
    end
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+logic
logic/rv_isa_pkg.sv
logic/mem_bus_pkg.sv
logic/byte_mem.sv
logic/mem_arbiter.sv
logic/lsu_port.sv
logic/ifetch_port.sv
logic/mem_subsystem.sv
verification/mem_subsystem_asserts.sv
verification/mem_subsystem_tb.sv
